//--- hdl/fm_pkg.sv
`default_nettype none

package fm_pkg;

	localparam int SAMPLE_WIDTH   = 16; // mixer output
	localparam int WAVE_WIDTH     = 14; // per-channel amplitude
	localparam int PHASE_WIDTH    = 20; // phase accumulator
	localparam int FNUM_WIDTH     = 10;
	localparam int BLOCK_WIDTH    = 3;
	localparam int ATTEN_WIDTH    = 4;
	localparam int WAVE_SEL_WIDTH = 2;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
	typedef logic signed [WAVE_WIDTH-1:0]   wave_t;
	typedef logic        [PHASE_WIDTH-1:0]  phase_t;
	typedef logic        [7:0]              reg_byte_t;

	// field code sits in addr[7:4], channel in addr[3:0]
	typedef enum logic [3:0] {
		FIELD_FNUM_LO = 4'h0, // fnum[7:0]
		FIELD_FNUM_HI = 4'h1, // fnum[9:8], block, key-on
		FIELD_VOICE   = 4'h2, // atten, waveform
		FIELD_PAN     = 4'h3  // left, right enables
	} reg_field_e;

	typedef enum logic [WAVE_SEL_WIDTH-1:0] {
		WAVE_OFF    = 2'd0,
		WAVE_SQUARE = 2'd1,
		WAVE_SAW    = 2'd2,
		WAVE_TRI    = 2'd3
	} wave_sel_e;

endpackage

`default_nettype wire

//--- hdl/fm_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module fm_reg_file #(
	parameter int NUM_CHANNELS = 4,
	localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        wr,
	input  logic                                        rd,
	input  logic [7:0]                                  addr,
	input  fm_pkg::reg_byte_t                           wr_data,
	output fm_pkg::reg_byte_t                           rd_data,
	output logic                                        rd_valid,
	output logic [NUM_CHANNELS*fm_pkg::FNUM_WIDTH-1:0]  fnum,
	output logic [NUM_CHANNELS*fm_pkg::BLOCK_WIDTH-1:0] block,
	output logic [NUM_CHANNELS-1:0]                     kon,
	output logic [NUM_CHANNELS*fm_pkg::ATTEN_WIDTH-1:0] atten,
	output logic [NUM_CHANNELS*fm_pkg::WAVE_SEL_WIDTH-1:0] wave,
	output logic [NUM_CHANNELS-1:0]                     pan_l,
	output logic [NUM_CHANNELS-1:0]                     pan_r
);

	fm_pkg::reg_byte_t fnum_lo_q [NUM_CHANNELS]; // full bytes kept for read-back
	fm_pkg::reg_byte_t fnum_hi_q [NUM_CHANNELS];
	fm_pkg::reg_byte_t voice_q   [NUM_CHANNELS];
	fm_pkg::reg_byte_t pan_q     [NUM_CHANNELS];

	fm_pkg::reg_field_e field;
	logic [IDX_W-1:0]   ch_sel;
	logic               ch_ok;
	fm_pkg::reg_byte_t  rd_byte;

	assign field  = fm_pkg::reg_field_e'(addr[7:4]);
	assign ch_sel = addr[IDX_W-1:0];
	assign ch_ok  = (32'(addr[3:0]) < NUM_CHANNELS); // out-of-range channels ignored

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int c = 0; c < NUM_CHANNELS; c++) begin
				fnum_lo_q[c] <= '0;
				fnum_hi_q[c] <= '0;
				voice_q[c]   <= '0;
				pan_q[c]     <= '0;
			end
		end else if (wr && ch_ok) begin
			case (field)
				fm_pkg::FIELD_FNUM_LO: fnum_lo_q[ch_sel] <= wr_data;
				fm_pkg::FIELD_FNUM_HI: fnum_hi_q[ch_sel] <= wr_data;
				fm_pkg::FIELD_VOICE:   voice_q[ch_sel]   <= wr_data;
				fm_pkg::FIELD_PAN:     pan_q[ch_sel]     <= wr_data;
				default: ; // undefined field, dropped
			endcase
		end
	end

	always_comb begin
		rd_byte = '0; // zero for bad field or channel
		if (ch_ok) begin
			case (field)
				fm_pkg::FIELD_FNUM_LO: rd_byte = fnum_lo_q[ch_sel];
				fm_pkg::FIELD_FNUM_HI: rd_byte = fnum_hi_q[ch_sel];
				fm_pkg::FIELD_VOICE:   rd_byte = voice_q[ch_sel];
				fm_pkg::FIELD_PAN:     rd_byte = pan_q[ch_sel];
				default:               rd_byte = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) rd_valid <= 1'b0;
		else rd_valid <= rd; // one cycle after the strobe
	end

	always_ff @(posedge clk) begin
		if (rd) rd_data <= rd_byte;
	end

	// unpack the bytes onto the per-channel buses
	for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_fields
		assign fnum[c*fm_pkg::FNUM_WIDTH +: fm_pkg::FNUM_WIDTH] = {fnum_hi_q[c][1:0], fnum_lo_q[c]};
		assign block[c*fm_pkg::BLOCK_WIDTH +: fm_pkg::BLOCK_WIDTH] = fnum_hi_q[c][4:2];
		assign kon[c] = fnum_hi_q[c][5];
		assign atten[c*fm_pkg::ATTEN_WIDTH +: fm_pkg::ATTEN_WIDTH] = voice_q[c][3:0];
		assign wave[c*fm_pkg::WAVE_SEL_WIDTH +: fm_pkg::WAVE_SEL_WIDTH] = voice_q[c][5:4];
		assign pan_l[c] = pan_q[c][0];
		assign pan_r[c] = pan_q[c][1];
	end

endmodule

`default_nettype wire

//--- hdl/fm_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fm_sequencer #(
	parameter int NUM_CHANNELS  = 4,
	parameter int CLK_DIV_COUNT = 32,
	localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
	input  logic             clk,
	input  logic             rst_n,
	output logic             ch_valid,
	output logic [IDX_W-1:0] ch_idx,
	output logic             ch_last
);

	localparam int DIV_W = (CLK_DIV_COUNT > 1) ? $clog2(CLK_DIV_COUNT) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;

	assign tick = (div_cnt == DIV_W'(CLK_DIV_COUNT - 1)); // one sample period boundary

	always_ff @(posedge clk) begin
		if (!rst_n) div_cnt <= '0;
		else if (tick) div_cnt <= '0;
		else div_cnt <= div_cnt + 1'b1;
	end

	// sweep runs one channel per clock starting the cycle after tick
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ch_valid <= 1'b0;
			ch_idx   <= '0;
			ch_last  <= 1'b0;
		end else if (tick) begin
			ch_valid <= 1'b1;
			ch_idx   <= '0;
			ch_last  <= (NUM_CHANNELS == 1); // single channel is also last
		end else if (ch_valid && !ch_last) begin
			ch_idx  <= ch_idx + 1'b1;
			ch_last <= (32'(ch_idx) == NUM_CHANNELS - 2); // next one is the last
		end else begin
			ch_valid <= 1'b0; // idle until next tick
			ch_last  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/fm_phase_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fm_phase_gen #(
	parameter int NUM_CHANNELS = 4,
	localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        ch_valid,
	input  logic [IDX_W-1:0]                            ch_idx,
	input  logic                                        ch_last,
	input  logic [NUM_CHANNELS*fm_pkg::FNUM_WIDTH-1:0]  fnum,
	input  logic [NUM_CHANNELS*fm_pkg::BLOCK_WIDTH-1:0] block,
	input  logic [NUM_CHANNELS-1:0]                     kon,
	output logic                                        ph_valid,
	output logic [IDX_W-1:0]                            ph_idx,
	output logic                                        ph_last,
	output logic                                        ph_active,
	output fm_pkg::phase_t                              phase
);

	fm_pkg::phase_t phase_mem [NUM_CHANNELS]; // one accumulator per channel

	logic [fm_pkg::FNUM_WIDTH-1:0]  fnum_sel;
	logic [fm_pkg::BLOCK_WIDTH-1:0] block_sel;
	fm_pkg::phase_t                 incr;
	fm_pkg::phase_t                 phase_next;

	assign fnum_sel   = fnum[ch_idx*fm_pkg::FNUM_WIDTH +: fm_pkg::FNUM_WIDTH];
	assign block_sel  = block[ch_idx*fm_pkg::BLOCK_WIDTH +: fm_pkg::BLOCK_WIDTH];
	assign incr       = fm_pkg::phase_t'(fnum_sel) << block_sel; // fnum * 2^block
	assign phase_next = phase_mem[ch_idx] + incr; // wraps at 2^20

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int c = 0; c < NUM_CHANNELS; c++) phase_mem[c] <= '0;
			ph_active <= 1'b0;
		end else if (ch_valid) begin
			if (kon[ch_idx]) begin
				phase_mem[ch_idx] <= phase_next;
				ph_active         <= 1'b1;
			end else begin
				phase_mem[ch_idx] <= '0; // key-off restarts from zero
				ph_active         <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ch_valid) phase <= kon[ch_idx] ? phase_next : '0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ph_valid <= 1'b0;
			ph_idx   <= '0;
			ph_last  <= 1'b0;
		end else begin
			ph_valid <= ch_valid; // sideband follows the phase one stage on
			ph_idx   <= ch_idx;
			ph_last  <= ch_last;
		end
	end

endmodule

`default_nettype wire

//--- hdl/fm_wave_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fm_wave_gen #(
	parameter int NUM_CHANNELS = 4,
	localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic                                           ph_valid,
	input  logic [IDX_W-1:0]                               ph_idx,
	input  logic                                           ph_last,
	input  logic                                           ph_active,
	input  fm_pkg::phase_t                                 phase,
	input  logic [NUM_CHANNELS*fm_pkg::ATTEN_WIDTH-1:0]    atten,
	input  logic [NUM_CHANNELS*fm_pkg::WAVE_SEL_WIDTH-1:0] wave,
	output logic                                           wv_valid,
	output logic [IDX_W-1:0]                               wv_idx,
	output logic                                           wv_last,
	output fm_pkg::wave_t                                  wv_value
);

	localparam int PW = fm_pkg::PHASE_WIDTH;

	fm_pkg::wave_sel_e              wave_sel;
	logic [fm_pkg::ATTEN_WIDTH-1:0] atten_sel;
	logic [12:0]                    tri_fold;
	fm_pkg::wave_t                  raw;

	assign wave_sel  = fm_pkg::wave_sel_e'(wave[ph_idx*fm_pkg::WAVE_SEL_WIDTH +:
		fm_pkg::WAVE_SEL_WIDTH]);
	assign atten_sel = atten[ph_idx*fm_pkg::ATTEN_WIDTH +: fm_pkg::ATTEN_WIDTH];

	// second half of the cycle runs the ramp back down
	assign tri_fold = phase[PW-1] ? ~phase[PW-2:PW-14] : phase[PW-2:PW-14];

	always_comb begin
		raw = '0;
		if (ph_active) begin
			case (wave_sel)
				fm_pkg::WAVE_SQUARE: raw = phase[PW-1] ? -14'sd8191 : 14'sd8191;
				fm_pkg::WAVE_SAW:    raw = fm_pkg::wave_t'(phase[PW-1:PW-14]); // top 14 bits
				fm_pkg::WAVE_TRI:    raw = fm_pkg::wave_t'({1'b0, tri_fold}) - 14'sd4096;
				default:             raw = '0; // WAVE_OFF
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ph_valid) wv_value <= raw >>> atten_sel; // 6 dB per step
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wv_valid <= 1'b0;
			wv_idx   <= '0;
			wv_last  <= 1'b0;
		end else begin
			wv_valid <= ph_valid;
			wv_idx   <= ph_idx;
			wv_last  <= ph_last;
		end
	end

endmodule

`default_nettype wire

//--- hdl/fm_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module fm_mixer #(
	parameter int NUM_CHANNELS = 4,
	localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wv_valid,
	input  logic [IDX_W-1:0]        wv_idx,
	input  logic                    wv_last,
	input  fm_pkg::wave_t           wv_value,
	input  logic [NUM_CHANNELS-1:0] pan_l,
	input  logic [NUM_CHANNELS-1:0] pan_r,
	output fm_pkg::sample_t         sample_l,
	output fm_pkg::sample_t         sample_r,
	output logic                    sample_valid
);

	fm_pkg::sample_t acc_l; // running sums over the sweep
	fm_pkg::sample_t acc_r;
	fm_pkg::sample_t value_ext;
	fm_pkg::sample_t sum_l;
	fm_pkg::sample_t sum_r;

	assign value_ext = fm_pkg::sample_t'(wv_value); // sign extended
	assign sum_l     = acc_l + (pan_l[wv_idx] ? value_ext : '0);
	assign sum_r     = acc_r + (pan_r[wv_idx] ? value_ext : '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_l        <= '0;
			acc_r        <= '0;
			sample_l     <= '0;
			sample_r     <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0; // single-cycle pulse
			if (wv_valid) begin
				if (wv_last) begin
					sample_l     <= sum_l; // publish finished frame
					sample_r     <= sum_r;
					sample_valid <= 1'b1;
					acc_l        <= '0;
					acc_r        <= '0;
				end else begin
					acc_l <= sum_l;
					acc_r <= sum_r;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/fm_synth_top.sv
`timescale 1ns/1ps
`default_nettype none

module fm_synth_top #(
	parameter int NUM_CHANNELS  = 4,
	parameter int CLK_DIV_COUNT = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr,
	input  logic              rd,
	input  logic [7:0]        addr,
	input  fm_pkg::reg_byte_t wr_data,
	output fm_pkg::reg_byte_t rd_data,
	output logic              rd_valid,
	output fm_pkg::sample_t   sample_l,
	output fm_pkg::sample_t   sample_r,
	output logic              sample_valid
);

	localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

	logic [NUM_CHANNELS*fm_pkg::FNUM_WIDTH-1:0]     fnum; // register bank to pipeline
	logic [NUM_CHANNELS*fm_pkg::BLOCK_WIDTH-1:0]    block;
	logic [NUM_CHANNELS-1:0]                        kon;
	logic [NUM_CHANNELS*fm_pkg::ATTEN_WIDTH-1:0]    atten;
	logic [NUM_CHANNELS*fm_pkg::WAVE_SEL_WIDTH-1:0] wave;
	logic [NUM_CHANNELS-1:0]                        pan_l;
	logic [NUM_CHANNELS-1:0]                        pan_r;

	logic             ch_valid, ph_valid, wv_valid; // per-stage strobes
	logic [IDX_W-1:0] ch_idx, ph_idx, wv_idx;
	logic             ch_last, ph_last, wv_last;
	logic             ph_active;
	fm_pkg::phase_t   phase;
	fm_pkg::wave_t    wv_value;

	fm_reg_file #(.NUM_CHANNELS(NUM_CHANNELS)) reg_file0 (.*);

	fm_sequencer #(
		.NUM_CHANNELS (NUM_CHANNELS),
		.CLK_DIV_COUNT(CLK_DIV_COUNT)
	) sequencer0 (.*);

	fm_phase_gen #(.NUM_CHANNELS(NUM_CHANNELS)) phase_gen0 (.*);
	fm_wave_gen  #(.NUM_CHANNELS(NUM_CHANNELS)) wave_gen0 (.*);
	fm_mixer     #(.NUM_CHANNELS(NUM_CHANNELS)) mixer0 (.*);

endmodule

`default_nettype wire

//--- dv/fm_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fm_clk_gen #(
	parameter int HALF_PERIOD  = 20, // ns, gives the 40 ns clock
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0; // low from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1; // released on a rising edge
	end

endmodule

`default_nettype wire

//--- dv/fm_synth_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fm_synth_checker #(
	parameter int CLK_DIV_COUNT = 32
) (
	input logic clk,
	input logic rst_n,
	input logic rd,
	input logic rd_valid,
	input logic sample_valid,
	input logic ch_valid
);

	logic rd_q; // rd one cycle ago
	logic sv_q; // sample_valid one cycle ago
	logic seen; // first pulse has gone by
	int   gap;  // cycles since last pulse
	logic rd_bad, double_bad, gap_bad, reset_bad;
	logic violation = 1'b0; // sticky, watched by the testbench

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_q <= 1'b0;
			sv_q <= 1'b0;
			seen <= 1'b0;
			gap  <= 0;
		end else begin
			rd_q <= rd;
			sv_q <= sample_valid;
			if (sample_valid) begin
				seen <= 1'b1;
				gap  <= 1;
			end else begin
				gap <= gap + 1;
			end
		end
	end

	assign rd_bad     = rst_n && (rd_valid != rd_q);
	assign double_bad = rst_n && sample_valid && sv_q; // back-to-back pulse
	assign gap_bad    = rst_n && seen &&
		(sample_valid ? (gap != CLK_DIV_COUNT) : (gap >= CLK_DIV_COUNT));
	assign reset_bad  = !rst_n && (ch_valid === 1'b1);

	always_ff @(posedge clk) begin
		if (rd_bad || double_bad || gap_bad || reset_bad) violation <= 1'b1;
	end

	a_rd_follows: assert property (@(posedge clk) !rd_bad)
		else $error("rd_valid does not follow rd by one cycle");
	a_pulse_width: assert property (@(posedge clk) !double_bad)
		else $error("sample_valid high on two consecutive cycles");
	a_pulse_gap: assert property (@(posedge clk) !gap_bad)
		else $error("sample_valid spacing differs from the divider period");
	a_reset_idle: assert property (@(posedge clk) !reset_bad)
		else $error("ch_valid high while in reset");

endmodule

bind fm_synth_top fm_synth_checker #(.CLK_DIV_COUNT(CLK_DIV_COUNT)) proto_chk0 (
	.clk         (clk),
	.rst_n       (rst_n),
	.rd          (rd),
	.rd_valid    (rd_valid),
	.sample_valid(sample_valid),
	.ch_valid    (ch_valid)
);

`default_nettype wire

//--- dv/fm_synth_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fm_synth_tb;

	localparam int NUM_CHANNELS  = 4; // matches the DUT defaults
	localparam int CLK_DIV_COUNT = 32;
	localparam int MAX_ROWS      = 16;
	localparam int HALF_TURN     = 1 << 19; // phase MSB weight

	logic              clk, rst_n, wr, rd, rd_valid, sample_valid;
	logic [7:0]        addr;
	fm_pkg::reg_byte_t wr_data, rd_data;
	fm_pkg::sample_t   sample_l, sample_r;

	string             row_name [MAX_ROWS];
	int                row_nwr  [MAX_ROWS];
	logic [7:0]        row_addr [MAX_ROWS][4];
	fm_pkg::reg_byte_t row_data [MAX_ROWS][4];
	logic [3:0]        row_rnd  [MAX_ROWS]; // msb marks first write as random
	int                row_nsmp [MAX_ROWS];
	int                n_rows = 0;
	int                limit_cycles = 0;
	fm_pkg::reg_byte_t shadow [4*NUM_CHANNELS]; // field * channels + channel
	int                ph_model [NUM_CHANNELS];

	fm_clk_gen #(.HALF_PERIOD(20), .RESET_CYCLES(5)) clk_gen0 (.clk(clk), .rst_n(rst_n));

	fm_synth_top dut0 (.*);

	task automatic stop_run();
		$display("ERRORS FOUND");
		$fatal(1, "run stopped on first failure");
	endtask

	task automatic compare_sample(input string name, input fm_pkg::sample_t exp,
		input fm_pkg::sample_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_reg(input string name, input fm_pkg::reg_byte_t exp,
		input fm_pkg::reg_byte_t act);
		if (act !== exp) begin
			$display("ERROR %s: expected 0x%02h, actual 0x%02h", name, exp, act);
			stop_run();
		end
	endtask

	function automatic bit addr_ok(input logic [7:0] a);
		return (int'(a[3:0]) < NUM_CHANNELS) && (int'(a[7:4]) < 4); // 4 defined fields
	endfunction

	function automatic int shadow_index(input logic [7:0] a);
		return int'(a[7:4]) * NUM_CHANNELS + int'(a[3:0]);
	endfunction

	function automatic fm_pkg::reg_byte_t expected_read(input logic [7:0] a);
		return addr_ok(a) ? shadow[shadow_index(a)] : 8'h00;
	endfunction

	// first write sits in the top byte of addrs and datas
	task automatic add_row(input string name, input int nwr, input logic [31:0] addrs,
		input logic [31:0] datas, input logic [3:0] rnd, input int nsmp);
		row_name[n_rows] = name;
		row_nwr[n_rows]  = nwr;
		row_rnd[n_rows]  = rnd;
		row_nsmp[n_rows] = nsmp;
		for (int i = 0; i < 4; i++) begin
			row_addr[n_rows][i] = addrs[31-8*i -: 8];
			row_data[n_rows][i] = datas[31-8*i -: 8];
		end
		n_rows++;
	endtask

	task automatic build_table();
		add_row("idle",     0, 32'h0,           32'h0,           4'b0000, 3);
		add_row("bad_addr", 4, 32'h05_41_F3_24, 32'hAA_55_12_3F, 4'b0000, 2);
		add_row("square_l", 4, 32'h30_20_00_10, 32'h01_10_00_3F, 4'b0010, 10); // ch0 left
		add_row("saw_l",    1, 32'h20_00_00_00, 32'h20_00_00_00, 4'b0000, 6);
		add_row("tri_l",    1, 32'h20_00_00_00, 32'h30_00_00_00, 4'b0000, 6);
		add_row("atten_1",  1, 32'h20_00_00_00, 32'h31_00_00_00, 4'b0000, 3);
		add_row("atten_5",  1, 32'h20_00_00_00, 32'h35_00_00_00, 4'b0000, 3);
		add_row("atten_15", 1, 32'h20_00_00_00, 32'h3F_00_00_00, 4'b0000, 3);
		add_row("ch1_on",   4, 32'h31_21_01_11, 32'h03_20_00_2A, 4'b0010, 2); // both sides
		add_row("ch2_on",   4, 32'h32_22_02_12, 32'h02_12_00_35, 4'b0010, 2); // right only
		add_row("ch3_on",   4, 32'h33_23_03_13, 32'h00_33_00_26, 4'b0010, 2); // no side
		add_row("four_ch",  1, 32'h20_00_00_00, 32'h10_00_00_00, 4'b0000, 8);
		add_row("key_off",  1, 32'h10_00_00_00, 32'h1F_00_00_00, 4'b0000, 3);
		add_row("key_on",   1, 32'h10_00_00_00, 32'h3F_00_00_00, 4'b0000, 3);
	endtask

	// one sweep of the reference, using the register bytes in force
	task automatic step_model(output int sum_l, output int sum_r);
		fm_pkg::reg_byte_t hi, voice, pan;
		int fnum, ph, raw, t, val;
		sum_l = 0;
		sum_r = 0;
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			hi    = shadow[NUM_CHANNELS + c];
			voice = shadow[2*NUM_CHANNELS + c];
			pan   = shadow[3*NUM_CHANNELS + c];
			fnum  = int'(hi[1:0]) * 256 + int'(shadow[c]);
			if (hi[5]) ph_model[c] = (ph_model[c] + (fnum << hi[4:2])) % (2 * HALF_TURN);
			else ph_model[c] = 0; // key-off clears phase
			ph  = ph_model[c];
			raw = 0;
			if (hi[5]) begin
				case (fm_pkg::wave_sel_e'(voice[5:4]))
					fm_pkg::WAVE_SQUARE: raw = (ph >= HALF_TURN) ? -8191 : 8191;
					fm_pkg::WAVE_SAW: begin
						raw = ph / 64; // top 14 bits
						if (raw >= 8192) raw = raw - 16384;
					end
					fm_pkg::WAVE_TRI: begin
						t = (ph / 64) % 8192;
						if (ph >= HALF_TURN) t = 8191 - t; // falling half
						raw = t - 4096;
					end
					default: raw = 0;
				endcase
			end
			val = raw >>> voice[3:0];
			if (pan[0]) sum_l = sum_l + val;
			if (pan[1]) sum_r = sum_r + val;
		end
	endtask

	task automatic check_sample(input string name);
		int exp_l, exp_r;
		do begin
			@(negedge clk); // outputs settled mid-cycle
		end while (!sample_valid);
		step_model(exp_l, exp_r);
		compare_sample({name, " left"}, fm_pkg::sample_t'(exp_l), sample_l);
		compare_sample({name, " right"}, fm_pkg::sample_t'(exp_r), sample_r);
	endtask

	task automatic read_back(input string name, input logic [7:0] a);
		@(posedge clk);
		rd   <= 1'b1;
		addr <= a;
		@(posedge clk);
		rd <= 1'b0;
		@(negedge clk); // data due one cycle after rd
		if (!rd_valid) begin
			$display("rd_valid did not rise one cycle after rd for %s", name);
			stop_run();
		end
		compare_reg({name, " readback"}, expected_read(a), rd_data);
	endtask

	task automatic apply_row(input int r);
		fm_pkg::reg_byte_t d;
		for (int i = 0; i < row_nwr[r]; i++) begin
			d = row_rnd[r][3-i] ? fm_pkg::reg_byte_t'($urandom) : row_data[r][i];
			@(posedge clk);
			wr      <= 1'b1;
			addr    <= row_addr[r][i];
			wr_data <= d;
			if (addr_ok(row_addr[r][i])) shadow[shadow_index(row_addr[r][i])] = d;
		end
		@(posedge clk);
		wr <= 1'b0;
		for (int i = 0; i < row_nwr[r]; i++) read_back(row_name[r], row_addr[r][i]);
	endtask

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, sample outputs stopped arriving");
		stop_run();
	end

	initial begin : protocol_watch
		wait (dut0.proto_chk0.violation === 1'b1);
		$display("a protocol assertion in the bound checker failed");
		stop_run();
	end

	initial begin : main
		int total;
		void'($urandom(54)); // seeds the thread generator
		wr      = 1'b0;
		rd      = 1'b0;
		addr    = 8'h00;
		wr_data = 8'h00;
		foreach (shadow[i]) shadow[i] = 8'h00;
		foreach (ph_model[i]) ph_model[i] = 0;
		build_table();
		total = 100; // margin for reset and first tick
		for (int r = 0; r < n_rows; r++)
			total = total + (row_nsmp[r] + 1) * CLK_DIV_COUNT * 2;
		limit_cycles = total;
		wait (rst_n === 1'b1);
		for (int r = 0; r < n_rows; r++) begin
			check_sample(row_name[r]); // sweep before this row's writes
			apply_row(r);
			repeat (row_nsmp[r]) check_sample(row_name[r]);
		end
		if (dut0.proto_chk0.violation === 1'b1) begin
			$display("a protocol assertion in the bound checker failed");
			stop_run();
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- files.f
hdl/fm_pkg.sv
hdl/fm_reg_file.sv
hdl/fm_sequencer.sv
hdl/fm_phase_gen.sv
hdl/fm_wave_gen.sv
hdl/fm_mixer.sv
hdl/fm_synth_top.sv
dv/fm_clk_gen.sv
dv/fm_synth_checker.sv
dv/fm_synth_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f files.f --top-module fm_synth_tb -o fm_synth_sim \
	&& ./obj_dir/fm_synth_sim +verilator+error+limit+100 \
	|| exit 1
